// File: verilog/fifo_macros.svh
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// Width of one item on the narrow write side
`define FIFO_W_DATA_W 8

// Narrow items per wide word, also the bank count
`define FIFO_RATIO 4

// Capacity counted in narrow items
`define FIFO_DEPTH_ITEMS 512

// Rows in each byte-wide bank
`define FIFO_ROWS (`FIFO_DEPTH_ITEMS / `FIFO_RATIO)

`endif

// File: verilog/stream_pkg.sv
`include "fifo_macros.svh"

package stream_pkg;

  // One item as written on the narrow side
  typedef logic [`FIFO_W_DATA_W-1:0] narrow_t;

  // One word as read on the wide side
  // Element 0 is lane 0 and sits in the low byte,
  // so the first item written into a word comes out lowest
  typedef narrow_t [`FIFO_RATIO-1:0] wide_t;

endpackage

// File: verilog/fifo_status_pkg.sv
`include "fifo_macros.svh"

package fifo_status_pkg;

  // Stored item count, 0 up to the full capacity inclusive
  typedef logic [$clog2(`FIFO_DEPTH_ITEMS + 1)-1:0] occupancy_t;

  // Row address shared by all banks
  typedef logic [$clog2(`FIFO_ROWS)-1:0] row_ptr_t;

  // Bank that takes the next narrow write
  typedef logic [$clog2(`FIFO_RATIO)-1:0] lane_t;

endpackage

// File: verilog/ram_port_if.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

// Write and read port of one memory bank
interface ram_port_if #(
  parameter type payload_t = logic [`FIFO_W_DATA_W-1:0],
  parameter type ptr_t     = logic [$clog2(`FIFO_ROWS)-1:0]
) (
  input logic clk
);

  // Write port
  logic     w_en;
  ptr_t     w_addr;
  payload_t w_data;

  // Read port, data registered inside the bank
  logic     r_en;
  ptr_t     r_addr;
  payload_t r_data;

  // Controller side
  modport ctrl (
    output w_en, w_addr, w_data,
    output r_en, r_addr,
    input  r_data
  );

  // Bank side
  modport mem (
    input  clk,
    input  w_en, w_addr, w_data,
    input  r_en, r_addr,
    output r_data
  );

endinterface

// File: verilog/lane_ram.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

// Simple dual-port memory bank
// Write and read are both synchronous to the port clock,
// the read behaves like a block RAM output register
module lane_ram #(
  parameter type         payload_t = logic [`FIFO_W_DATA_W-1:0],
  parameter int unsigned ROWS      = `FIFO_ROWS
) (
  ram_port_if.mem port
);

  // Storage array
  payload_t mem [ROWS];

  // Write port
  always_ff @(posedge port.clk) begin
    if (port.w_en) begin
      mem[port.w_addr] <= port.w_data;
    end
  end

  // Read port
  // The output holds the last row read until the next enabled read
  always_ff @(posedge port.clk) begin
    if (port.r_en) begin
      port.r_data <= mem[port.r_addr];
    end
  end

endmodule

// File: verilog/narrow_wide_fifo.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

// Synchronous narrow-to-wide FIFO
// Narrow items are striped over RATIO byte-wide banks,
// one wide read pulls the same row out of every bank
module narrow_wide_fifo (
  input  logic                       clk,
  input  logic                       rst,

  // Narrow write side
  input  stream_pkg::narrow_t        w_data,
  input  logic                       write_en,
  output logic                       full,

  // Wide read side
  input  logic                       read_en,
  output logic                       empty,
  output stream_pkg::wide_t          r_data,
  output logic                       r_valid,

  // Fill level in narrow items
  output fifo_status_pkg::occupancy_t occupancy
);

  import stream_pkg::*;
  import fifo_status_pkg::*;

  localparam occupancy_t DEPTH_ITEMS = occupancy_t'(`FIFO_DEPTH_ITEMS);
  localparam occupancy_t WORD_ITEMS  = occupancy_t'(`FIFO_RATIO);
  localparam lane_t      LAST_LANE   = lane_t'(`FIFO_RATIO - 1);

  // Qualified strobes
  logic write_acc;
  logic read_acc;

  // Pointers
  lane_t    w_lane;
  row_ptr_t w_row;
  row_ptr_t r_row;

  // Registered outputs of the banks, one per lane
  narrow_t bank_q [`FIFO_RATIO];

  // Status flags straight from the item count
  // Empty means less than one whole word stored
  assign full  = (occupancy == DEPTH_ITEMS);
  assign empty = (occupancy < WORD_ITEMS);

  // Strobes at full or empty are dropped silently
  assign write_acc = write_en & ~full;
  assign read_acc  = read_en & ~empty;

  // Occupancy in narrow items
  // A write adds one item, a read removes a whole word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      occupancy <= '0;
    end else begin
      case ({write_acc, read_acc})
        2'b10: begin
          occupancy <= occupancy + occupancy_t'(1);
        end
        2'b01: begin
          occupancy <= occupancy - WORD_ITEMS;
        end
        2'b11: begin
          occupancy <= occupancy - WORD_ITEMS + occupancy_t'(1);
        end
        default: begin
          occupancy <= occupancy;
        end
      endcase
    end
  end

  // Lane index for the next write
  // Wraps from the last lane back to lane 0 by its width
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_lane <= '0;
    end else if (write_acc) begin
      w_lane <= w_lane + lane_t'(1);
    end
  end

  // Write row moves on once the last lane of a row is filled
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_row <= '0;
    end else if (write_acc && (w_lane == LAST_LANE)) begin
      w_row <= w_row + row_ptr_t'(1);
    end
  end

  // Read row moves on with every accepted read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      r_row <= '0;
    end else if (read_acc) begin
      r_row <= r_row + row_ptr_t'(1);
    end
  end

  // Bank data is ready one edge after the accepted read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= read_acc;
    end
  end

  // One bank per lane
  for (genvar i = 0; i < `FIFO_RATIO; i++) begin : g_lane
    ram_port_if #(
      .payload_t (narrow_t),
      .ptr_t     (row_ptr_t)
    ) bank_if (
      .clk (clk)
    );

    // Only the lane under the write index takes the item
    assign bank_if.w_en   = write_acc && (w_lane == lane_t'(i));
    assign bank_if.w_addr = w_row;
    assign bank_if.w_data = w_data;

    // All lanes read the same row together
    assign bank_if.r_en   = read_acc;
    assign bank_if.r_addr = r_row;

    lane_ram #(
      .payload_t (narrow_t),
      .ROWS      (`FIFO_ROWS)
    ) bank_i (
      .port (bank_if.mem)
    );

    assign bank_q[i] = bank_if.r_data;
  end

  // Word assembly, bank i goes to byte i
  always_comb begin
    for (int i = 0; i < `FIFO_RATIO; i++) begin
      r_data[i] = bank_q[i];
    end
  end

endmodule

// File: verilog/narrow_wide_buffer_top.sv
`timescale 1ns/1ns

// Top level of the width-converting buffer
// Plain ports only, the banks and their port bundles stay inside
module narrow_wide_buffer_top (
  input  logic                        clk,
  input  logic                        rst,

  // Narrow write side
  input  stream_pkg::narrow_t         w_data,
  input  logic                        write_en,
  output logic                        full,

  // Wide read side
  input  logic                        read_en,
  output logic                        empty,
  output stream_pkg::wide_t           r_data,
  output logic                        r_valid,

  // Fill level in narrow items
  output fifo_status_pkg::occupancy_t occupancy
);

  // Buffer core, no extra cycles on any path
  narrow_wide_fifo fifo_i (
    .clk       (clk),
    .rst       (rst),
    .w_data    (w_data),
    .write_en  (write_en),
    .full      (full),
    .read_en   (read_en),
    .empty     (empty),
    .r_data    (r_data),
    .r_valid   (r_valid),
    .occupancy (occupancy)
  );

endmodule

// File: verification/narrow_wide_buffer_checks.svh
// Error counters, one per kind of result
int word_errors;
int occupancy_errors;
int flag_errors;
int other_errors;

// Read data against the word popped from the model
task automatic check_word(
  input string name,
  input wide_t exp,
  input wide_t act
);
  if (act !== exp) begin
    word_errors++;
    $display("FAILED %s at %0t: expected %h, actual %h", name, $time, exp, act);
  end
endtask

// Item count against the model count
task automatic check_occupancy(
  input string      name,
  input occupancy_t exp,
  input occupancy_t act
);
  if (act !== exp) begin
    occupancy_errors++;
    $display("FAILED %s at %0t: expected %0d, actual %0d", name, $time, exp, act);
  end
endtask

// Single status bit, used for full and empty
task automatic check_flag(
  input string name,
  input logic  exp,
  input logic  act
);
  if (act !== exp) begin
    flag_errors++;
    $display("FAILED %s at %0t: expected %b, actual %b", name, $time, exp, act);
  end
endtask

// Anything that has no expected value to show
task automatic report_problem(
  input string what
);
  other_errors++;
  $display("ERROR at %0t: %s", $time, what);
endtask

// Sum over all counters
function automatic int total_errors();
  int total;
  total = word_errors + occupancy_errors + flag_errors + other_errors;
  return total;
endfunction

// Closing line with every counter
task automatic print_error_counts();
  $display("Error counts: word %0d, occupancy %0d, flag %0d, other %0d",
           word_errors, occupancy_errors, flag_errors, other_errors);
endtask

// File: verification/narrow_wide_buffer_tb.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

module narrow_wide_buffer_tb;

  import stream_pkg::*;
  import fifo_status_pkg::*;

  localparam int unsigned SEED         = 32'h898d_52ec;
  localparam int RESET_CYCLES          = 16;
  localparam int STIM_CYCLES           = 4000;
  localparam int TIMEOUT_CYCLES        = STIM_CYCLES + RESET_CYCLES + 100;
  localparam int PHASE_CYCLES          = 1000;
  localparam int DEPTH                 = `FIFO_DEPTH_ITEMS;
  localparam int WORD_ITEMS            = `FIFO_RATIO;

  // DUT signals
  logic       clk;
  logic       rst;
  narrow_t    w_data;
  logic       write_en;
  logic       full;
  logic       read_en;
  logic       empty;
  wide_t      r_data;
  logic       r_valid;
  occupancy_t occupancy;

  // Model state
  narrow_t model_q[$];
  bit      model_on;
  bit      exp_valid;
  wide_t   exp_word;
  int      cycle_count;

  `include "narrow_wide_buffer_checks.svh"

  narrow_wide_buffer_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .w_data    (w_data),
    .write_en  (write_en),
    .full      (full),
    .read_en   (read_en),
    .empty     (empty),
    .r_data    (r_data),
    .r_valid   (r_valid),
    .occupancy (occupancy)
  );

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

  // True with the given chance in percent
  function automatic bit chance(input int pct);
    return int'($urandom_range(99, 0)) < pct;
  endfunction

  // Fill, drain, balanced, then refill and drain with many reads
  task automatic drive_cycle(input int cycle);
    int wr_pct;
    int rd_pct;
    case (cycle / PHASE_CYCLES)
      0: begin
        wr_pct = 95;
        rd_pct = 3;
      end
      1: begin
        wr_pct = 15;
        rd_pct = 60;
      end
      2: begin
        wr_pct = 80;
        rd_pct = 20;
      end
      default: begin
        if ((cycle % PHASE_CYCLES) < (PHASE_CYCLES / 2)) begin
          wr_pct = 90;
          rd_pct = 10;
        end else begin
          wr_pct = 50;
          rd_pct = 50;
        end
      end
    endcase
    write_en <= chance(wr_pct);
    read_en  <= chance(rd_pct);
    w_data   <= narrow_t'($urandom);
  endtask

  // Acceptance decided from the model count before this edge
  task automatic update_model();
    bit    w_acc;
    bit    r_acc;
    wide_t word;
    w_acc = (write_en === 1'b1) && (model_q.size() < DEPTH);
    r_acc = (read_en === 1'b1) && (model_q.size() >= WORD_ITEMS);
    if (r_acc) begin
      // Earliest item goes to lane 0, the low byte
      for (int k = 0; k < WORD_ITEMS; k++) begin
        word[k] = model_q.pop_front();
      end
      exp_word = word;
    end
    if (w_acc) begin
      model_q.push_back(w_data);
    end
    exp_valid = r_acc;
  endtask

  task automatic finish_run();
    print_error_counts();
    if (total_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    if (model_on) begin
      update_model();
    end
  end

  // Outputs are compared mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (model_on) begin
      check_occupancy("occupancy", occupancy_t'(model_q.size()), occupancy);
      check_flag("full flag", model_q.size() == DEPTH, full);
      check_flag("empty flag", model_q.size() < WORD_ITEMS, empty);
      if (exp_valid) begin
        if (r_valid === 1'b1) begin
          check_word("packing", exp_word, r_data);
        end else begin
          report_problem("no r_valid in the cycle after an accepted read");
        end
      end else if (r_valid !== 1'b0) begin
        report_problem("r_valid high with no read outstanding");
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_problem("run did not finish within the cycle limit");
      finish_run();
    end
  end

  initial begin
    void'($urandom(SEED));
    rst      = 1'b1;
    write_en = 1'b0;
    read_en  = 1'b0;
    w_data   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst      <= 1'b0;
    model_on <= 1'b1;

    @(negedge clk);
    check_occupancy("reset occupancy", '0, occupancy);
    check_flag("reset empty", 1'b1, empty);
    check_flag("reset full", 1'b0, full);
    check_flag("reset r_valid", 1'b0, r_valid);

    for (int i = 0; i < STIM_CYCLES; i++) begin
      @(posedge clk);
      drive_cycle(i);
    end

    // Let the last read come out
    @(posedge clk);
    write_en <= 1'b0;
    read_en  <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    // Past the last mid-cycle compare
    #1;
    finish_run();
  end

endmodule

// File: project.f
+incdir+verilog
+incdir+verification
verilog/stream_pkg.sv
verilog/fifo_status_pkg.sv
verilog/ram_port_if.sv
verilog/lane_ram.sv
verilog/narrow_wide_fifo.sv
verilog/narrow_wide_buffer_top.sv
verification/narrow_wide_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -f project.f \
  --top-module narrow_wide_buffer_tb -o narrow_wide_buffer_sim > build.log 2>&1 \
  && ./obj_dir/narrow_wide_buffer_sim > sim.log 2>&1 \
  || { echo "Build or run failed, see build.log and sim.log"; exit 1; }

grep -q "SIMULATION PASSED" sim.log \
  && echo "Test passed" \
  || { echo "Test failed, see sim.log"; exit 1; }
